// ==== conv_pixels_top.f ====
+incdir+common
common/pixels_pkg.sv
verilog/loop_counter.sv
verilog/edge_ram.sv
verilog/stream_width_adapter.sv
pixel_streamer/pixel_streamer.sv
verilog/conv_pixels_top.sv
dv/tb_clock_gen.sv
dv/conv_pixels_props.sv
dv/conv_pixels_tb.sv

// ==== dv/conv_pixels_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pixels_defs.svh"

module conv_pixels_tb;

  import pixels_pkg::*;

  localparam int LANES    = `AXI_WIDTH / `WORD_WIDTH;
  localparam int IMG_COLS = `XW_MAX * `CI_MAX;
  localparam int PAT_LEN  = 1024;
  localparam int CI_W     = `CI_BITS;
  localparam int XW_W     = `XW_BITS;
  localparam int BLK_W    = `BLK_BITS;
  localparam int KH2_W    = `KH2_BITS;

  logic                     aclk;
  logic                     aresetn;
  logic                     i_s_valid;
  logic                     o_s_ready;
  logic                     i_s_last;
  beat_t                    i_s_data;
  keep_t                    i_s_keep;
  logic [`HEADER_WIDTH-1:0] i_s_user;
  logic                     o_m_valid;
  logic                     i_m_ready;
  logic                     o_m_last;
  rows_t                    o_m_data;

  // Input beats and expected output beats of the current run
  beat_t                    in_data_q[$];
  keep_t                    in_keep_q[$];
  logic                     in_last_q[$];
  logic [`HEADER_WIDTH-1:0] in_user_q[$];
  rows_t                    exp_data_q[$];
  logic                     exp_last_q[$];

  // Image rows by column slot x*CI_MAX+c
  word_t                    img [`XH_MAX][IMG_COLS];
  bit                       ready_pat [PAT_LEN];
  integer                   seed = 92202;

  tb_clock_gen #(.PERIOD_NS(20)) clock_gen_i (.aclk(aclk));

  conv_pixels_top conv_pixels_top_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_last  (i_s_last),
    .i_s_data  (i_s_data),
    .i_s_keep  (i_s_keep),
    .i_s_user  (i_s_user),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_last  (o_m_last),
    .o_m_data  (o_m_data)
  );

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  // Half kernel heights above the halo depth fall back to 0
  function automatic int limit_kh2(input int kh2_field);
    return (kh2_field <= `EDGE_WORDS) ? kh2_field : 0;
  endfunction

  function automatic int out_beats(input int ch, input int w, input int blocks, input int kh2_field);
    return blocks * w * ch * (2 * limit_kh2(kh2_field) + 1);
  endfunction

  function automatic word_t pixel(input int row, input int x, input int c, input int height);
    if (row < 0 || row >= height) begin
      return '0;
    end
    return img[row][x * `CI_MAX + c];
  endfunction

  // Splits one column into beats, either dense or two words on odd lanes
  task automatic add_column(input word_t words[$], input logic [`HEADER_WIDTH-1:0] user,
                            input bit sparse, input bit last);
    beat_t data;
    keep_t keep;
    int    idx;
    int    lane;
    int    per_beat;
    per_beat = sparse ? 2 : LANES;
    idx = 0;
    while (idx < words.size()) begin
      data = $random(seed);
      keep = '0;
      for (int j = 0; j < per_beat && idx < words.size(); j++) begin
        lane = sparse ? 2 * j + 1 : j;
        data[lane] = words[idx];
        keep[lane] = 1'b1;
        idx++;
      end
      in_data_q.push_back(data);
      in_keep_q.push_back(keep);
      in_last_q.push_back(last && (idx == words.size()));
      in_user_q.push_back(user);
    end
  endtask

  task automatic add_packet(input int ch, input int w, input int blocks, input int kh2_field,
                            input bit mixed_keep);
    pixel_header_t hdr;
    word_t         words[$];
    rows_t         exp;
    int            kh2;
    int            height;
    int            col;
    bit            last_col;
    kh2 = limit_kh2(kh2_field);
    height = blocks * `ROWS;
    hdr.ci_m1     = CI_W'(ch - 1);
    hdr.w_m1      = XW_W'(w - 1);
    hdr.blocks_m1 = BLK_W'(blocks - 1);
    hdr.kh2       = KH2_W'(kh2_field);
    for (int r = 0; r < height; r++) begin
      for (int i = 0; i < IMG_COLS; i++) begin
        img[r][i] = word_t'($random(seed));
      end
    end
    col = 0;
    for (int b = 0; b < blocks; b++) begin
      for (int x = 0; x < w; x++) begin
        for (int c = 0; c < ch; c++) begin
          last_col = (b == blocks - 1) && (x == w - 1) && (c == ch - 1);
          words.delete();
          // Bottom halo word is the next block's first row
          for (int r = 0; r < `ROWS + kh2; r++) begin
            words.push_back(pixel(b * `ROWS + r, x, c, height));
          end
          add_column(words, hdr, mixed_keep && (col % 2 == 1), last_col);
          for (int k = 0; k <= 2 * kh2; k++) begin
            for (int r = 0; r < `ROWS; r++) begin
              exp[r] = pixel(b * `ROWS + r + k - kh2, x, c, height);
            end
            exp_data_q.push_back(exp);
            exp_last_q.push_back(last_col && (k == 2 * kh2));
          end
          col++;
        end
      end
    end
  endtask

  task automatic clear_queues();
    in_data_q.delete();
    in_keep_q.delete();
    in_last_q.delete();
    in_user_q.delete();
    exp_data_q.delete();
    exp_last_q.delete();
  endtask

  task automatic send_beats(input bit gaps);
    int n_gap;
    for (int i = 0; i < in_data_q.size(); i++) begin
      n_gap = gaps ? {$random(seed)} % 3 : 0;
      repeat (n_gap) begin
        i_s_valid = 1'b0;
        @(negedge aclk);
      end
      i_s_valid = 1'b1;
      i_s_data  = in_data_q[i];
      i_s_keep  = in_keep_q[i];
      i_s_last  = in_last_q[i];
      i_s_user  = in_user_q[i];
      #1;
      while (!o_s_ready) begin
        @(negedge aclk);
        #1;
      end
      @(negedge aclk);
    end
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
    i_s_keep  = '0;
  endtask

  task automatic check_beat(input int idx);
    assert (o_m_data == exp_data_q[idx])
      else report_failure($sformatf("Mismatch at %0d ns: o_m_data of beat %0d is %h, expected %h",
                                    $time, idx, o_m_data, exp_data_q[idx]));
    assert (o_m_last == exp_last_q[idx])
      else report_failure($sformatf("Mismatch at %0d ns: o_m_last of beat %0d is %b, expected %b",
                                    $time, idx, o_m_last, exp_last_q[idx]));
  endtask

  // Outputs are registered, so they are sampled just after the falling edge
  task automatic collect_beats(input bit gaps);
    int idx;
    int cycle;
    idx = 0;
    cycle = 0;
    while (idx < exp_data_q.size()) begin
      i_m_ready = gaps ? ready_pat[cycle % PAT_LEN] : 1'b1;
      #1;
      if (o_m_valid && i_m_ready) begin
        check_beat(idx);
        idx++;
      end
      cycle++;
      @(negedge aclk);
    end
    i_m_ready = 1'b0;
    #1;
    assert (!o_m_valid)
      else report_failure("o_m_valid stayed high after the final output beat");
  endtask

  task automatic run_stream(input bit gaps);
    for (int i = 0; i < PAT_LEN; i++) begin
      ready_pat[i] = ({$random(seed)} % 3) != 0;
    end
    fork
      send_beats(gaps);
      collect_beats(gaps);
    join
  endtask

  task automatic no_halo_columns();
    $display("Test 1: kh2 0 with mixed keep packing");
    clear_queues();
    add_packet(2, 4, 2, 0, 1'b1);
    run_stream(1'b0);
  endtask

  task automatic one_block_halo();
    $display("Test 2: kh2 1, one block, fifth word in its own beat");
    clear_queues();
    add_packet(3, 3, 1, 1, 1'b0);
    run_stream(1'b0);
  endtask

  task automatic three_block_halo();
    $display("Test 3: kh2 1, three blocks with top halo from the edge RAM");
    clear_queues();
    add_packet(2, 4, 3, 1, 1'b1);
    run_stream(1'b0);
  endtask

  // Same stimulus and expected beats as the three block test
  task automatic random_gap_rerun();
    $display("Test 4: three blocks again with random valid and ready gaps");
    run_stream(1'b1);
  endtask

  task automatic back_to_back_packets();
    $display("Test 5: two packets back to back");
    clear_queues();
    add_packet(2, 3, 2, 1, 1'b0);
    add_packet(3, 2, 1, 2, 1'b1);
    run_stream(1'b0);
  endtask

  initial begin : watchdog
    int limit;
    limit = 40 * (out_beats(2, 4, 2, 0) + out_beats(3, 3, 1, 1) + 2 * out_beats(2, 4, 3, 1) +
                  out_beats(2, 3, 2, 1) + out_beats(3, 2, 1, 2)) + 1000;
    repeat (limit) @(posedge aclk);
    report_failure($sformatf("Timeout: the tests did not finish within %0d cycles", limit));
  end

  initial begin
    aresetn   = 1'b0;
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
    i_s_data  = '0;
    i_s_keep  = '0;
    i_s_user  = '0;
    i_m_ready = 1'b0;
    repeat (2) @(negedge aclk);
    aresetn = 1'b1;
    no_halo_columns();
    one_block_halo();
    three_block_halo();
    random_gap_rerun();
    back_to_back_packets();
    if (conv_pixels_top_i.pixel_streamer_i.props_i.fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("Property checks failed %0d times",
               conv_pixels_top_i.pixel_streamer_i.props_i.fail_count);
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/conv_pixels_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module conv_pixels_props (
  input wire logic              aclk,
  input wire logic              aresetn,
  input wire logic              i_s_valid,
  input wire logic              i_s_ready,
  input wire logic              i_m_valid,
  input wire logic              i_m_ready,
  input wire logic              i_m_last,
  input wire pixels_pkg::rows_t i_m_data
);

  int unsigned fail_count = 0;
  logic        idle_q;

  // Idle from reset or the final output beat until a header is seen
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      idle_q <= 1'b1;
    end else if (idle_q) begin
      if (i_s_valid) begin
        idle_q <= 1'b0;
      end
    end else if (i_m_valid && i_m_ready && i_m_last) begin
      idle_q <= 1'b1;
    end
  end

  // Output beat holds under back-pressure
  hold_while_stalled: assert property (@(posedge aclk) disable iff (!aresetn)
    i_m_valid && !i_m_ready |=> i_m_valid && $stable(i_m_data))
    else begin
      $error("o_m_valid or o_m_data changed while i_m_ready was low");
      fail_count++;
    end

  no_ready_in_idle: assert property (@(posedge aclk) disable iff (!aresetn)
    idle_q |-> !i_s_ready)
    else begin
      $error("o_s_ready was high while the streamer was idle");
      fail_count++;
    end

  last_needs_valid: assert property (@(posedge aclk) disable iff (!aresetn)
    i_m_last |-> i_m_valid)
    else begin
      $error("o_m_last was high without o_m_valid");
      fail_count++;
    end

endmodule

bind pixel_streamer conv_pixels_props props_i (
  .aclk      (aclk),
  .aresetn   (aresetn),
  .i_s_valid (i_s_valid),
  .i_s_ready (o_s_ready),
  .i_m_valid (o_m_valid),
  .i_m_ready (i_m_ready),
  .i_m_last  (o_m_last),
  .i_m_data  (o_m_data)
);

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic aclk
);

  initial begin
    aclk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) aclk = ~aclk;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/conv_pixels_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pixels_defs.svh"

module conv_pixels_top (
  input  wire logic                     aclk,
  input  wire logic                     aresetn,
  input  wire logic                     i_s_valid,
  output logic                          o_s_ready,
  input  wire logic                     i_s_last,
  input  wire pixels_pkg::beat_t        i_s_data,
  input  wire pixels_pkg::keep_t        i_s_keep,
  input  wire logic [`HEADER_WIDTH-1:0] i_s_user,
  output logic                          o_m_valid,
  input  wire logic                     i_m_ready,
  output logic                          o_m_last,
  output pixels_pkg::rows_t             o_m_data
);

  // Pixel stream in, row windows out
  pixel_streamer pixel_streamer_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_last  (i_s_last),
    .i_s_data  (i_s_data),
    .i_s_keep  (i_s_keep),
    .i_s_user  (i_s_user),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_last  (o_m_last),
    .o_m_data  (o_m_data)
  );

endmodule

`default_nettype wire

// ==== pixel_streamer/pixel_streamer.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pixels_defs.svh"

module pixel_streamer (
  input  wire logic                     aclk,
  input  wire logic                     aresetn,
  input  wire logic                     i_s_valid,
  output logic                          o_s_ready,
  input  wire logic                     i_s_last,
  input  wire pixels_pkg::beat_t        i_s_data,
  input  wire pixels_pkg::keep_t        i_s_keep,
  input  wire logic [`HEADER_WIDTH-1:0] i_s_user,
  output logic                          o_m_valid,
  input  wire logic                     i_m_ready,
  output logic                          o_m_last,
  output pixels_pkg::rows_t             o_m_data
);

  import pixels_pkg::*;

  localparam int KH_W    = `KH_BITS;
  localparam int ADDR_W  = $clog2(`RAM_EDGES_DEPTH);
  localparam int SHIFT_N = `ROWS + 2 * `EDGE_WORDS;

  typedef enum logic [1:0] {S_IDLE, S_PASS, S_DRAIN} state_t;

  state_t                  state_q;
  pixel_header_t           hdr_in;
  logic [`KH2_BITS-1:0]    kh2_lim;
  logic [`KH2_BITS-1:0]    kh2_q;
  logic [KH_W-1:0]         kh_max;
  logic                    use_edges;

  logic                    ro_s_valid, ro_s_ready, ro_m_valid, ro_m_ready, ro_m_last;
  logic                    re_s_valid, re_s_ready, re_m_valid, re_m_ready, re_m_last;
  rows_t                   ro_m_data;
  rows_edges_t             re_m_data;
  rows_edges_t             col_data;
  logic                    col_valid, col_last;

  logic                    en_config, en_shift, en_kh, en_copy;
  logic                    last_kh, last_clk_kh, last_clk_ci, last_clk_w, first_l, last_l;
  logic                    copy_r, last_r, last_kh_r, last_clk_kh_r, first_l_r, last_l_r;
  logic                    m_last_q, s_last_beat, m_last_beat;
  rows_edges_t             col_data_r;

  logic [ADDR_W-1:0]       ram_addr, addr_r, ram_addr_in;
  logic                    ram_ren, ram_wen, ram_ren_q;
  edge_t                   ram_dout, ram_hold, edge_top, edge_bot;
  word_t [SHIFT_N-1:0]     shift_q;

  assign hdr_in    = i_s_user;
  assign kh2_lim   = (hdr_in.kh2 <= `EDGE_WORDS) ? hdr_in.kh2 : '0;
  assign kh_max    = KH_W'(2 * kh2_lim);
  assign use_edges = (kh2_q != '0);

  assign s_last_beat = i_s_valid && o_s_ready && i_s_last;
  assign m_last_beat = o_m_valid && i_m_ready && o_m_last;

  // Header is read in idle without giving ready
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= S_IDLE;
      kh2_q   <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (i_s_valid) begin
            state_q <= S_PASS;
            kh2_q   <= kh2_lim;
          end
        end
        S_PASS: begin
          if (s_last_beat) begin
            state_q <= m_last_beat ? S_IDLE : S_DRAIN;
          end
        end
        default: begin
          if (m_last_beat) begin
            state_q <= S_IDLE;
          end
        end
      endcase
    end
  end

  assign en_config = (state_q == S_IDLE);
  assign en_shift  = !en_config && i_m_ready;
  // Kernel row counter waits at its last row for a column, or runs out the final one
  assign en_kh     = en_shift && (!last_kh || col_valid || m_last_q || last_r);
  assign en_copy   = en_shift && col_valid && last_clk_kh;

  assign ro_s_valid = (state_q == S_PASS) && !use_edges && i_s_valid;
  assign re_s_valid = (state_q == S_PASS) && use_edges && i_s_valid;
  assign o_s_ready  = (state_q == S_PASS) && (use_edges ? re_s_ready : ro_s_ready);
  assign ro_m_ready = !use_edges && en_copy;
  assign re_m_ready = use_edges && en_copy;

  stream_width_adapter #(.t_out(rows_t)) adapter_rows_i (
    .aclk    (aclk),
    .aresetn (aresetn),
    .i_valid (ro_s_valid),
    .o_ready (ro_s_ready),
    .i_last  (i_s_last),
    .i_data  (i_s_data),
    .i_keep  (i_s_keep),
    .o_valid (ro_m_valid),
    .i_ready (ro_m_ready),
    .o_last  (ro_m_last),
    .o_data  (ro_m_data)
  );

  stream_width_adapter #(.t_out(rows_edges_t)) adapter_edges_i (
    .aclk    (aclk),
    .aresetn (aresetn),
    .i_valid (re_s_valid),
    .o_ready (re_s_ready),
    .i_last  (i_s_last),
    .i_data  (i_s_data),
    .i_keep  (i_s_keep),
    .o_valid (re_m_valid),
    .i_ready (re_m_ready),
    .o_last  (re_m_last),
    .o_data  (re_m_data)
  );

  // Zero halo when no rows below are needed
  assign col_data  = use_edges ? re_m_data : {edge_t'('0), ro_m_data};
  assign col_valid = use_edges ? re_m_valid : ro_m_valid;
  assign col_last  = use_edges ? re_m_last : ro_m_last;

  loop_counter #(.W(KH_W)) kh_cnt_i (
    .aclk(aclk), .aresetn(aresetn), .i_load(en_config), .i_en(en_kh), .i_max(kh_max),
    .o_last_clk(last_clk_kh), .o_last(last_kh), .o_first()
  );
  loop_counter #(.W(`CI_BITS)) ci_cnt_i (
    .aclk(aclk), .aresetn(aresetn), .i_load(en_config), .i_en(last_clk_kh),
    .i_max(hdr_in.ci_m1), .o_last_clk(last_clk_ci), .o_last(), .o_first()
  );
  loop_counter #(.W(`XW_BITS)) w_cnt_i (
    .aclk(aclk), .aresetn(aresetn), .i_load(en_config), .i_en(last_clk_ci),
    .i_max(hdr_in.w_m1), .o_last_clk(last_clk_w), .o_last(), .o_first()
  );
  loop_counter #(.W(`BLK_BITS)) blk_cnt_i (
    .aclk(aclk), .aresetn(aresetn), .i_load(en_config), .i_en(last_clk_w),
    .i_max(hdr_in.blocks_m1), .o_last_clk(), .o_last(last_l), .o_first(first_l)
  );

  // Channel and width position inside a block
  always_ff @(posedge aclk) begin
    if (!aresetn || en_config || last_clk_w) begin
      ram_addr <= '0;
    end else if (en_copy) begin
      ram_addr <= ram_addr + 1'b1;
    end
  end

  // Stage matching the RAM read latency
  always_ff @(posedge aclk) begin
    if (!aresetn || en_config) begin
      {copy_r, last_r, last_kh_r, last_clk_kh_r, first_l_r, last_l_r} <= '0;
    end else if (en_shift) begin
      copy_r        <= en_copy;
      last_r        <= en_copy && col_last;
      last_kh_r     <= last_kh;
      last_clk_kh_r <= last_clk_kh;
      first_l_r     <= first_l;
      last_l_r      <= last_l;
    end
  end

  always_ff @(posedge aclk) begin
    if (en_shift) begin
      col_data_r <= col_data;
      addr_r     <= ram_addr;
    end
  end

  assign ram_ren     = en_copy && !first_l;
  assign ram_wen     = copy_r && !last_l_r;
  assign ram_addr_in = ram_wen ? addr_r : ram_addr;
  assign edge_bot    = col_data_r[`ROWS-1 -: `EDGE_WORDS];

  edge_ram edge_ram_i (
    .aclk   (aclk),
    .i_en   (ram_ren || ram_wen),
    .i_we   (ram_wen),
    .i_addr (ram_addr_in),
    .i_din  (edge_bot),
    .o_dout (ram_dout)
  );

  // Keeps read data through an output stall
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ram_ren_q <= 1'b0;
    end else begin
      ram_ren_q <= ram_ren;
    end
  end

  always_ff @(posedge aclk) begin
    if (ram_ren_q) begin
      ram_hold <= ram_dout;
    end
  end

  assign edge_top = first_l_r ? '0 : (ram_ren_q ? ram_dout : ram_hold);

  always_ff @(posedge aclk) begin
    if (en_shift) begin
      if (copy_r) begin
        shift_q <= {col_data_r, edge_top};
      end else begin
        shift_q <= shift_q >> `WORD_WIDTH;
      end
    end
  end

  always_comb begin
    for (int r = 0; r < `ROWS; r++) begin
      o_m_data[r] = shift_q[r + `EDGE_WORDS - int'(kh2_q)];
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn || m_last_beat) begin
      o_m_valid <= 1'b0;
      m_last_q  <= 1'b0;
    end else if (en_shift) begin
      if (copy_r) begin
        m_last_q <= last_r;
      end
      if (last_kh_r) begin
        o_m_valid <= copy_r;
      end
    end
  end

  // Final kernel row of the final column
  assign o_m_last = m_last_q && last_clk_kh_r;

endmodule

`default_nettype wire

// ==== verilog/stream_width_adapter.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pixels_defs.svh"

module stream_width_adapter #(
  parameter type t_out = pixels_pkg::rows_t
) (
  input  wire logic              aclk,
  input  wire logic              aresetn,
  input  wire logic              i_valid,
  output logic                   o_ready,
  input  wire logic              i_last,
  input  wire pixels_pkg::beat_t i_data,
  input  wire pixels_pkg::keep_t i_keep,
  output logic                   o_valid,
  input  wire logic              i_ready,
  output logic                   o_last,
  output t_out                   o_data
);

  import pixels_pkg::*;

  localparam int BEAT_WORDS = `AXI_WIDTH / `WORD_WIDTH;
  localparam int OUT_WORDS  = $bits(t_out) / `WORD_WIDTH;
  localparam int CW         = $clog2(OUT_WORDS + BEAT_WORDS + 1);

  word_t [OUT_WORDS-1:0] pack_q;
  word_t [OUT_WORDS-1:0] pack_d;
  logic [CW-1:0]         cnt_q;
  logic [CW-1:0]         pos;
  logic                  full;
  logic                  take;

  // Accept while empty or while the held payload leaves
  assign o_ready = !o_valid || i_ready;
  assign take    = i_valid && o_ready;

  // Kept words go to the next free slots in order
  always_comb begin
    pack_d = pack_q;
    pos    = cnt_q;
    for (int i = 0; i < BEAT_WORDS; i++) begin
      if (i_keep[i]) begin
        if (pos < CW'(OUT_WORDS)) begin
          pack_d[pos] = i_data[i];
        end
        pos = pos + 1'b1;
      end
    end
  end

  assign full = (pos >= CW'(OUT_WORDS));

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cnt_q   <= '0;
      o_valid <= 1'b0;
      o_last  <= 1'b0;
    end else begin
      if (o_valid && i_ready) begin
        o_valid <= 1'b0;
      end
      if (take) begin
        if (full) begin
          cnt_q   <= '0;
          o_valid <= 1'b1;
          o_last  <= i_last;
        end else begin
          cnt_q <= pos;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      pack_q <= pack_d;
    end
  end

  assign o_data = pack_q;

endmodule

`default_nettype wire

// ==== verilog/edge_ram.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pixels_defs.svh"

module edge_ram (
  input  wire logic                                aclk,
  input  wire logic                                i_en,
  input  wire logic                                i_we,
  input  wire logic [$clog2(`RAM_EDGES_DEPTH)-1:0] i_addr,
  input  wire pixels_pkg::edge_t                   i_din,
  output pixels_pkg::edge_t                        o_dout
);

  import pixels_pkg::*;

  edge_t mem [`RAM_EDGES_DEPTH];

  // Read first, old contents come out during a write
  always_ff @(posedge aclk) begin
    if (i_en) begin
      o_dout <= mem[i_addr];
      if (i_we) begin
        mem[i_addr] <= i_din;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/loop_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module loop_counter #(
  parameter int W = 4
) (
  input  wire logic         aclk,
  input  wire logic         aresetn,
  input  wire logic         i_load,
  input  wire logic         i_en,
  input  wire logic [W-1:0] i_max,
  output logic              o_last_clk,
  output logic              o_last,
  output logic              o_first
);

  logic [W-1:0] count_q;
  logic [W-1:0] max_q;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      count_q <= '0;
      max_q   <= '0;
    end else if (i_load) begin
      count_q <= '0;
      max_q   <= i_max;
    end else if (i_en) begin
      if (o_last) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign o_last  = (count_q == max_q);
  assign o_first = (count_q == '0);

  // Wrap strobe, drives the next outer loop
  assign o_last_clk = i_en && o_last;

endmodule

`default_nettype wire

// ==== common/pixels_pkg.sv ====
`default_nettype none
`include "pixels_defs.svh"

package pixels_pkg;

  // One pixel word
  typedef logic [`WORD_WIDTH-1:0] word_t;

  // Words and keep bits of one input beat
  typedef word_t [`AXI_WIDTH/`WORD_WIDTH-1:0] beat_t;
  typedef logic [`AXI_WIDTH/`WORD_WIDTH-1:0] keep_t;

  // One column, row 0 at index 0
  typedef word_t [`ROWS-1:0] rows_t;

  // One column followed by its bottom halo
  typedef word_t [`ROWS+`EDGE_WORDS-1:0] rows_edges_t;

  // Halo rows kept between blocks
  typedef word_t [`EDGE_WORDS-1:0] edge_t;

  // Start of packet header on the user field
  typedef struct packed {
    logic [`CI_BITS-1:0]  ci_m1;
    logic [`XW_BITS-1:0]  w_m1;
    logic [`BLK_BITS-1:0] blocks_m1;
    logic [`KH2_BITS-1:0] kh2;
  } pixel_header_t;

endpackage

`default_nettype wire

// ==== common/pixels_defs.svh ====
`ifndef PIXELS_DEFS_SVH
`define PIXELS_DEFS_SVH

// Image and kernel limits
`define ROWS            4
`define KH_MAX          3
`define CI_MAX          4
`define XW_MAX          8
`define XH_MAX          16

// Word and bus widths
`define WORD_WIDTH      8
`define AXI_WIDTH       32
`define RAM_EDGES_DEPTH 32

// Halo rows above and below a block
`define EDGE_WORDS      (`KH_MAX / 2)

// Header field widths
`define CI_BITS         $clog2(`CI_MAX)
`define XW_BITS         $clog2(`XW_MAX)
`define BLK_BITS        $clog2(`XH_MAX / `ROWS)
`define KH_BITS         $clog2(`KH_MAX)
`define KH2_BITS        $clog2(`KH_MAX)
`define HEADER_WIDTH    (`CI_BITS + `XW_BITS + `BLK_BITS + `KH2_BITS)

`endif
